// File: logic/tlu_timing_pkg.sv
// TLU timing package
// handshake timing constants and the field types of the serial
// trigger-number protocol
`default_nettype none

package tlu_timing_pkg;

    localparam int CLK_DIVISOR            = 8;   // trigger clocks per TLU bit
    localparam int MAX_TLU_BITS           = 32;  // used when the cycle setting is 0
    localparam int HISTORY_LEN            = MAX_TLU_BITS * CLK_DIVISOR;
    localparam int TRIGGER_LOW_MIN_CYCLES = 5;   // masks glitches on the trigger line
    localparam int SYNC_DELAY_CYCLES      = 3;   // minimum delay through the synchronizer

    typedef enum logic
    {
        MODE_FLAG      = 1'b0,
        MODE_HANDSHAKE = 1'b1
    } tlu_mode_t;

    typedef logic [4:0] tlu_cycles_t;   // 0 means 32 bits
    typedef logic [3:0] tlu_delay_t;
    typedef logic [7:0] low_timeout_t;  // 0 disables the timeout

    typedef logic [HISTORY_LEN-1:0] tlu_history_t;

endpackage

`default_nettype wire

// File: logic/trigger_word_pkg.sv
// Trigger word package
// output data word, timestamp and trigger counter types
`default_nettype none

package trigger_word_pkg;

    localparam int WORD_WIDTH = 32;

    // always set so the word stands out in the readout stream
    localparam int WORD_MARKER_BIT = WORD_WIDTH - 1;

    typedef logic [WORD_WIDTH-1:0] trigger_word_t;
    typedef logic [WORD_WIDTH-1:0] timestamp_t;
    typedef logic [WORD_WIDTH-1:0] trigger_count_t;
    typedef logic [WORD_WIDTH-1:0] tlu_number_t;

endpackage

`default_nettype wire

// File: logic/tlu_handshake_fsm.sv
// TLU handshake FSM
// accepts a trigger, waits for the TLU line to fall, clocks the trigger
// number out and strobes the sampler; outputs are registered from next state
`timescale 1ns/1ns
`default_nettype none

module tlu_handshake_fsm
(
    input  wire                           TRIGGER_CLK,
    input  wire                           RESET,
    input  wire                           trigger,
    input  wire                           trigger_flag,
    input  wire                           trigger_veto,
    input  wire                           trigger_enable,
    input  wire                           trigger_acknowledge,
    input  wire tlu_timing_pkg::tlu_mode_t    tlu_mode,
    input  wire tlu_timing_pkg::tlu_cycles_t  tlu_clock_cycles,
    input  wire tlu_timing_pkg::tlu_delay_t   tlu_data_delay,
    input  wire tlu_timing_pkg::low_timeout_t tlu_low_timeout,
    output logic                          trigger_accepted_flag,
    output logic                          latch_strobe,
    output logic                          tlu_busy,
    output logic                          tlu_clock_enable,
    output logic                          tlu_assert_veto,
    output logic                          tlu_low_timeout_error,
    output logic                          tlu_accept_error
);
    import tlu_timing_pkg::*;

    typedef enum logic [2:0]
    {
        IDLE,
        WAIT_LOW,
        SEND_CLOCK,
        WAIT_LATCH,
        LATCH,
        WAIT_ACK
    } state_t;

    state_t       state;
    state_t       next_state;
    logic         accept;
    logic         acknowledged;  // ack seen since acceptance
    low_timeout_t wait_cnt;
    logic [8:0]   clk_cnt;
    logic [4:0]   delay_cnt;
    logic [8:0]   clock_target;
    logic [4:0]   delay_target;

    assign clock_target = (tlu_clock_cycles == '0) ? 9'(MAX_TLU_BITS * CLK_DIVISOR)
                                                   : 9'(tlu_clock_cycles * CLK_DIVISOR);
    assign delay_target = 5'(tlu_data_delay + SYNC_DELAY_CYCLES);

    // veto only blocks plain flags, the TLU has its own veto line
    assign accept = !trigger_acknowledge && trigger_enable &&
                    ((tlu_mode == MODE_FLAG) ? (trigger_flag && !trigger_veto)
                                             : (trigger || trigger_flag));

    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:
                if (accept)
                    next_state = WAIT_LOW;
            WAIT_LOW:
                if (tlu_mode == MODE_FLAG)
                    next_state = LATCH;  // nothing to clock out
                else if ((!trigger || tlu_low_timeout_error) &&
                         (wait_cnt >= 8'(TRIGGER_LOW_MIN_CYCLES)))
                    next_state = SEND_CLOCK;
            SEND_CLOCK:
                if (clk_cnt == clock_target)
                    next_state = WAIT_LATCH;
            WAIT_LATCH:
                if (delay_cnt == delay_target)
                    next_state = LATCH;
            LATCH:
                next_state = WAIT_ACK;
            WAIT_ACK:
                if (trigger_acknowledge || acknowledged)
                    next_state = IDLE;
            default:
                next_state = IDLE;
        endcase
    end

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
        begin
            state                 <= IDLE;
            trigger_accepted_flag <= 1'b0;
            latch_strobe          <= 1'b0;
            tlu_busy              <= 1'b0;
            tlu_clock_enable      <= 1'b0;
            tlu_assert_veto       <= 1'b0;
            tlu_low_timeout_error <= 1'b0;
            tlu_accept_error      <= 1'b0;
            acknowledged          <= 1'b0;
            wait_cnt              <= '0;
            clk_cnt               <= '0;
            delay_cnt             <= '0;
        end
        else
        begin
            state                 <= next_state;
            trigger_accepted_flag <= (state == IDLE) && (next_state == WAIT_LOW);
            latch_strobe          <= (next_state == LATCH);
            tlu_clock_enable      <= (next_state == SEND_CLOCK);
            tlu_busy              <= (next_state != IDLE);  // drops as ack ends the cycle

            // wait counter saturates so a stuck line cannot wrap it
            if (next_state != WAIT_LOW)
                wait_cnt <= '0;
            else if (wait_cnt != '1)
                wait_cnt <= wait_cnt + 8'd1;

            clk_cnt   <= (next_state == SEND_CLOCK) ? clk_cnt + 9'd1 : '0;
            delay_cnt <= (next_state == WAIT_LATCH) ? delay_cnt + 5'd1 : '0;

            if (next_state == IDLE)
            begin
                tlu_assert_veto       <= !trigger_enable || trigger_veto;
                tlu_accept_error      <= trigger && trigger_enable;  // line high while idle
                tlu_low_timeout_error <= 1'b0;
                acknowledged          <= 1'b0;
            end
            else
            begin
                if (trigger_acknowledge)
                    acknowledged <= 1'b1;
                if ((next_state == WAIT_LOW) && (tlu_low_timeout != '0) &&
                    (wait_cnt >= tlu_low_timeout))
                    tlu_low_timeout_error <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/tlu_number_sampler.sv
// TLU number sampler
// keeps a history of the trigger line and latches the trigger number
// from it, in either bit order
`timescale 1ns/1ns
`default_nettype none

module tlu_number_sampler
(
    input  wire                            TRIGGER_CLK,
    input  wire                            RESET,
    input  wire                            trigger,
    input  wire                            latch_strobe,
    input  wire tlu_timing_pkg::tlu_cycles_t   tlu_clock_cycles,
    input  wire                            tlu_msb_first,
    output trigger_word_pkg::tlu_number_t  tlu_number,
    output logic                           number_valid
);
    import tlu_timing_pkg::*;
    import trigger_word_pkg::*;

    tlu_history_t history;  // position 0 is the newest sample
    logic [5:0]   n_bits;
    logic [7:0]   skip_len;
    logic [7:0]   lsb_base;
    tlu_number_t  msb_sel;
    tlu_number_t  lsb_sel;
    tlu_number_t  keep_mask;

    assign n_bits    = (tlu_clock_cycles == '0) ? 6'(MAX_TLU_BITS) : {1'b0, tlu_clock_cycles};
    assign skip_len  = 8'((MAX_TLU_BITS - n_bits) * CLK_DIVISOR);
    assign lsb_base  = 8'(HISTORY_LEN - 1) - skip_len;
    assign keep_mask = (32'd1 << (n_bits - 6'd1)) - 32'd1;  // bits 0 to N-2

    // one tap per bit, sampled at the end of each bit period
    for (genvar n = 0; n < MAX_TLU_BITS; n++)
    begin : g_tap
        localparam logic [7:0] STEP = 8'(n * CLK_DIVISOR + CLK_DIVISOR);

        assign msb_sel[n] = history[8'(n * CLK_DIVISOR + CLK_DIVISOR - 1)];
        assign lsb_sel[n] = history[lsb_base - STEP];  // mirrored order
    end

    always_ff @(posedge TRIGGER_CLK)
    begin
        history <= {history[HISTORY_LEN-2:0], trigger};
        if (latch_strobe)
            tlu_number <= (tlu_msb_first ? msb_sel : lsb_sel) & keep_mask;
    end

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
            number_valid <= 1'b0;
        else
            number_valid <= latch_strobe;
    end

endmodule

`default_nettype wire

// File: logic/trigger_word_builder.sv
// Trigger word builder
// free-running timestamp and trigger counter, captured on acceptance,
// and the marked 32-bit output word
`timescale 1ns/1ns
`default_nettype none

module trigger_word_builder
(
    input  wire                              TRIGGER_CLK,
    input  wire                              RESET,
    input  wire                              trigger_accepted_flag,
    input  wire                              number_valid,
    input  wire trigger_word_pkg::tlu_number_t   tlu_number,
    input  wire tlu_timing_pkg::tlu_mode_t       tlu_mode,
    input  wire                              write_timestamp,
    input  wire                              counter_set,
    input  wire trigger_word_pkg::trigger_count_t counter_set_value,
    output trigger_word_pkg::trigger_word_t  trigger_data,
    output logic                             trigger_data_write,
    output trigger_word_pkg::timestamp_t     timestamp
);
    import tlu_timing_pkg::*;
    import trigger_word_pkg::*;

    trigger_count_t trigger_counter;
    timestamp_t     captured_ts;
    trigger_count_t captured_cnt;
    trigger_word_t  word_source;

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
        begin
            timestamp       <= '0;
            trigger_counter <= '0;
        end
        else
        begin
            timestamp <= timestamp + 32'd1;
            if (counter_set)
                trigger_counter <= counter_set_value;
            else if (trigger_accepted_flag)
                trigger_counter <= trigger_counter + 32'd1;  // counts after capture
        end
    end

    // values closest to the trigger
    always_ff @(posedge TRIGGER_CLK)
    begin
        if (trigger_accepted_flag)
        begin
            captured_ts  <= timestamp;
            captured_cnt <= trigger_counter;
        end
    end

    always_comb
    begin
        if (write_timestamp)
            word_source = captured_ts;
        else if (tlu_mode == MODE_HANDSHAKE)
            word_source = tlu_number;
        else
            word_source = captured_cnt;
    end

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (number_valid)
            trigger_data <= {1'b1, word_source[WORD_MARKER_BIT-1:0]};
    end

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
            trigger_data_write <= 1'b0;
        else
            trigger_data_write <= number_valid;
    end

endmodule

`default_nettype wire

// File: logic/tlu_controller.sv
// TLU controller top
// handshake FSM, TLU number sampler and trigger word builder
`timescale 1ns/1ns
`default_nettype none

module tlu_controller
(
    input  wire                               TRIGGER_CLK,
    input  wire                               RESET,
    input  wire                               trigger,
    input  wire                               trigger_flag,
    input  wire                               trigger_veto,
    input  wire                               trigger_enable,
    input  wire                               trigger_acknowledge,
    input  wire tlu_timing_pkg::tlu_mode_t        tlu_mode,
    input  wire tlu_timing_pkg::tlu_cycles_t      tlu_clock_cycles,
    input  wire tlu_timing_pkg::tlu_delay_t       tlu_data_delay,
    input  wire tlu_timing_pkg::low_timeout_t     tlu_low_timeout,
    input  wire                               tlu_msb_first,
    input  wire                               write_timestamp,
    input  wire                               counter_set,
    input  wire trigger_word_pkg::trigger_count_t counter_set_value,
    output trigger_word_pkg::trigger_word_t   trigger_data,
    output logic                              trigger_data_write,
    output trigger_word_pkg::timestamp_t      timestamp,
    output logic                              trigger_accepted_flag,
    output logic                              tlu_busy,
    output logic                              tlu_clock_enable,
    output logic                              tlu_assert_veto,
    output logic                              tlu_low_timeout_error,
    output logic                              tlu_accept_error
);
    import trigger_word_pkg::*;

    logic        latch_strobe;
    tlu_number_t tlu_number;
    logic        number_valid;

    tlu_handshake_fsm i_fsm
    (
        .TRIGGER_CLK           (TRIGGER_CLK),
        .RESET                 (RESET),
        .trigger               (trigger),
        .trigger_flag          (trigger_flag),
        .trigger_veto          (trigger_veto),
        .trigger_enable        (trigger_enable),
        .trigger_acknowledge   (trigger_acknowledge),
        .tlu_mode              (tlu_mode),
        .tlu_clock_cycles      (tlu_clock_cycles),
        .tlu_data_delay        (tlu_data_delay),
        .tlu_low_timeout       (tlu_low_timeout),
        .trigger_accepted_flag (trigger_accepted_flag),
        .latch_strobe          (latch_strobe),
        .tlu_busy              (tlu_busy),
        .tlu_clock_enable      (tlu_clock_enable),
        .tlu_assert_veto       (tlu_assert_veto),
        .tlu_low_timeout_error (tlu_low_timeout_error),
        .tlu_accept_error      (tlu_accept_error)
    );

    // same trigger line as the FSM, it carries the serial number
    tlu_number_sampler i_sampler
    (
        .TRIGGER_CLK      (TRIGGER_CLK),
        .RESET            (RESET),
        .trigger          (trigger),
        .latch_strobe     (latch_strobe),
        .tlu_clock_cycles (tlu_clock_cycles),
        .tlu_msb_first    (tlu_msb_first),
        .tlu_number       (tlu_number),
        .number_valid     (number_valid)
    );

    trigger_word_builder i_builder
    (
        .TRIGGER_CLK           (TRIGGER_CLK),
        .RESET                 (RESET),
        .trigger_accepted_flag (trigger_accepted_flag),
        .number_valid          (number_valid),
        .tlu_number            (tlu_number),
        .tlu_mode              (tlu_mode),
        .write_timestamp       (write_timestamp),
        .counter_set           (counter_set),
        .counter_set_value     (counter_set_value),
        .trigger_data          (trigger_data),
        .trigger_data_write    (trigger_data_write),
        .timestamp             (timestamp)
    );

endmodule

`default_nettype wire

// File: verif/tb_tlu_controller.sv
// TLU controller testbench
// directed tests of flag mode, the TLU handshake with a line model,
// the low timeout and the accept error
`timescale 1ns/1ns
`default_nettype none

module tb_tlu_controller;
    import tlu_timing_pkg::*;
    import trigger_word_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 10;
    localparam int SAMPLE_DELAY = 1;     // outputs settled after the edge
    localparam int SEED         = 47481;
    localparam int FLAG_CYCLES  = 16;    // one flag trigger including ack
    localparam int HS_CYCLES    = HISTORY_LEN + 48;  // longest handshake and wait limit
    localparam int WATCHDOG_CYCLES = 8 + (5 * FLAG_CYCLES + 8) + 5 * HS_CYCLES + 8 + 200;

    logic           TRIGGER_CLK;
    logic           RESET;
    logic           trigger;
    logic           trigger_flag;
    logic           trigger_veto;
    logic           trigger_enable;
    logic           trigger_acknowledge;
    tlu_mode_t      tlu_mode;
    tlu_cycles_t    tlu_clock_cycles;
    tlu_delay_t     tlu_data_delay;
    low_timeout_t   tlu_low_timeout;
    logic           tlu_msb_first;
    logic           write_timestamp;
    logic           counter_set;
    trigger_count_t counter_set_value;
    trigger_word_t  trigger_data;
    logic           trigger_data_write;
    timestamp_t     timestamp;
    logic           trigger_accepted_flag;
    logic           tlu_busy;
    logic           tlu_clock_enable;
    logic           tlu_assert_veto;
    logic           tlu_low_timeout_error;
    logic           tlu_accept_error;

    tlu_history_t   line_hist;  // line values from the TLU model with the newest at 0
    tlu_history_t   hist_d1;
    tlu_history_t   hist_d2;    // history at the latch edge
    timestamp_t     ts_model;
    trigger_count_t cnt_model;
    int             enable_total = 0;
    int             mismatch_count = 0;
    int             fail_count = 0;

    tlu_controller i_dut
    (
        .TRIGGER_CLK           (TRIGGER_CLK),
        .RESET                 (RESET),
        .trigger               (trigger),
        .trigger_flag          (trigger_flag),
        .trigger_veto          (trigger_veto),
        .trigger_enable        (trigger_enable),
        .trigger_acknowledge   (trigger_acknowledge),
        .tlu_mode              (tlu_mode),
        .tlu_clock_cycles      (tlu_clock_cycles),
        .tlu_data_delay        (tlu_data_delay),
        .tlu_low_timeout       (tlu_low_timeout),
        .tlu_msb_first         (tlu_msb_first),
        .write_timestamp       (write_timestamp),
        .counter_set           (counter_set),
        .counter_set_value     (counter_set_value),
        .trigger_data          (trigger_data),
        .trigger_data_write    (trigger_data_write),
        .timestamp             (timestamp),
        .trigger_accepted_flag (trigger_accepted_flag),
        .tlu_busy              (tlu_busy),
        .tlu_clock_enable      (tlu_clock_enable),
        .tlu_assert_veto       (tlu_assert_veto),
        .tlu_low_timeout_error (tlu_low_timeout_error),
        .tlu_accept_error      (tlu_accept_error)
    );

    initial
    begin
        TRIGGER_CLK = 1'b0;
        forever #(CLK_PERIOD / 2) TRIGGER_CLK = ~TRIGGER_CLK;
    end

    always @(posedge TRIGGER_CLK)
    begin
        line_hist <= {line_hist[HISTORY_LEN-2:0], trigger};
        hist_d1   <= line_hist;
        hist_d2   <= hist_d1;
        ts_model  <= RESET ? '0 : ts_model + 32'd1;  // free-running after reset
        if (tlu_clock_enable)
            enable_total <= enable_total + 1;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge TRIGGER_CLK);
        $display("watchdog expired after %0d cycles, the tests did not finish",
                 WATCHDOG_CYCLES);
        $display("Errors found");
        $finish;
    end

    function automatic trigger_word_t mark_word(input logic [WORD_WIDTH-1:0] value);
        return {1'b1, value[WORD_MARKER_BIT-1:0]};
    endfunction

    // number from the line history by the sampler bit rule
    function automatic tlu_number_t predict_number(input tlu_history_t hist,
                                                   input tlu_cycles_t cycles_cfg,
                                                   input logic msb);
        int          n;
        int          pos;
        tlu_number_t result;
        n = (cycles_cfg == '0) ? MAX_TLU_BITS : int'(cycles_cfg);
        result = '0;
        for (int b = 0; b <= n - 2; b++)
        begin
            if (msb)
                pos = b * CLK_DIVISOR + CLK_DIVISOR - 1;
            else
                pos = HISTORY_LEN - 1 - (MAX_TLU_BITS - n) * CLK_DIVISOR
                      - (b + 1) * CLK_DIVISOR;
            result[b] = hist[pos];
        end
        return result;
    endfunction

    task automatic check_word(input string name, input trigger_word_t expected,
                              input trigger_word_t actual);
        if (actual !== expected)
        begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic check_count(input string name, input trigger_count_t expected,
                               input trigger_count_t actual);
        if (actual !== expected)
        begin
            $display("Mismatch in %s: expected %0d, actual %0d", name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("Mismatch in %s: expected %b, actual %b", name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic next_cycle();
        @(posedge TRIGGER_CLK);
        #(SAMPLE_DELAY);
    endtask

    task automatic wait_drive_point();
        #(DRIVE_DELAY - SAMPLE_DELAY);
    endtask

    task automatic wait_write(input string name, output int cycles);
        next_cycle();
        cycles = 1;
        while (!trigger_data_write && cycles < HS_CYCLES)
        begin
            next_cycle();
            cycles++;
        end
        if (!trigger_data_write)
        begin
            $display("%s: no trigger word was written within %0d cycles", name, HS_CYCLES);
            fail_count++;
        end
    endtask

    task automatic acknowledge_trigger(input string name);
        check_bit({name, " busy before ack"}, 1'b1, tlu_busy);
        wait_drive_point();
        trigger_acknowledge = 1'b1;
        next_cycle();
        check_bit({name, " busy after ack"}, 1'b0, tlu_busy);
        wait_drive_point();
        trigger_acknowledge = 1'b0;
        next_cycle();
    endtask

    task automatic run_flag(input string name, input logic use_ts);
        trigger_word_t expected;
        int            latency;
        wait_drive_point();
        trigger_flag = 1'b1;
        next_cycle();
        check_bit({name, " accepted"}, 1'b1, trigger_accepted_flag);
        if (use_ts)
            check_word({name, " timestamp"}, ts_model, timestamp);
        expected  = mark_word(use_ts ? ts_model : cnt_model);
        cnt_model = cnt_model + 32'd1;  // counts after the capture
        wait_drive_point();
        trigger_flag = 1'b0;
        wait_write(name, latency);
        check_count({name, " latency"}, 32'd3, trigger_count_t'(latency));
        check_word(name, expected, trigger_data);
        acknowledge_trigger(name);
    endtask

    task automatic run_handshake(input string name, input tlu_cycles_t cycles_cfg,
                                 input logic msb, input logic hold_high);
        tlu_number_t number;
        int          n_bits;
        int          waited;
        int          enable_start;
        int          latency;
        number       = $urandom();
        n_bits       = (cycles_cfg == '0) ? MAX_TLU_BITS : int'(cycles_cfg);
        enable_start = enable_total;
        wait_drive_point();
        tlu_clock_cycles = cycles_cfg;
        tlu_msb_first    = msb;
        trigger          = 1'b1;  // TLU raises the line
        next_cycle();
        check_bit({name, " accepted"}, 1'b1, trigger_accepted_flag);
        cnt_model = cnt_model + 32'd1;
        if (hold_high)
        begin
            waited = 0;
            while (!tlu_low_timeout_error && waited < HS_CYCLES)
            begin
                next_cycle();
                waited++;
            end
            check_bit({name, " error raised"}, 1'b1, tlu_low_timeout_error);
        end
        else
        begin
            wait_drive_point();
            trigger = 1'b0;  // answer to busy
        end
        waited = 0;
        while (!tlu_clock_enable && waited < HS_CYCLES)
        begin
            next_cycle();
            waited++;
        end
        if (!tlu_clock_enable)
        begin
            $display("%s: the TLU clock was never enabled", name);
            fail_count++;
        end
        for (int b = 0; b < n_bits; b++)
        begin
            wait_drive_point();
            trigger = number[b];  // one bit per bit period from the lsb
            repeat (CLK_DIVISOR) next_cycle();
        end
        wait_drive_point();
        trigger = 1'b0;
        wait_write(name, latency);
        check_word(name, mark_word(predict_number(hist_d2, cycles_cfg, msb)), trigger_data);
        check_count({name, " clock cycles"}, trigger_count_t'(n_bits * CLK_DIVISOR),
                    trigger_count_t'(enable_total - enable_start));
        acknowledge_trigger(name);
        if (hold_high)
            check_bit({name, " error cleared"}, 1'b0, tlu_low_timeout_error);
    endtask

    task automatic test_reset_idle();
        repeat (2) next_cycle();
        check_bit("reset accepted flag", 1'b0, trigger_accepted_flag);
        check_bit("reset data write", 1'b0, trigger_data_write);
        check_bit("reset busy", 1'b0, tlu_busy);
        check_bit("reset clock enable", 1'b0, tlu_clock_enable);
        check_bit("reset veto", 1'b0, tlu_assert_veto);
        check_bit("reset low timeout", 1'b0, tlu_low_timeout_error);
        check_bit("reset accept error", 1'b0, tlu_accept_error);
        check_word("reset timestamp", '0, timestamp);
        wait_drive_point();
        RESET = 1'b0;
        repeat (2) next_cycle();
        check_bit("veto while disabled", 1'b1, tlu_assert_veto);
        wait_drive_point();
        trigger_enable = 1'b1;
        repeat (2) next_cycle();
        check_bit("veto when enabled", 1'b0, tlu_assert_veto);
    endtask

    task automatic test_flag_counter();
        run_flag("counter first", 1'b0);
        run_flag("counter second", 1'b0);
        wait_drive_point();
        counter_set       = 1'b1;
        counter_set_value = 32'h4000_0a5c;
        next_cycle();
        wait_drive_point();
        counter_set = 1'b0;
        cnt_model   = counter_set_value;
        next_cycle();
        run_flag("counter loaded", 1'b0);
        run_flag("counter after load", 1'b0);
    endtask

    task automatic test_flag_timestamp();
        logic seen;
        wait_drive_point();
        write_timestamp = 1'b1;
        next_cycle();
        run_flag("timestamp", 1'b1);
        wait_drive_point();
        write_timestamp = 1'b0;
        trigger_veto    = 1'b1;
        trigger_flag    = 1'b1;
        seen = 1'b0;
        repeat (4)
        begin
            next_cycle();
            seen = seen | trigger_accepted_flag;
        end
        check_bit("vetoed flag", 1'b0, seen);
        check_bit("veto output", 1'b1, tlu_assert_veto);
        wait_drive_point();
        trigger_flag = 1'b0;
        trigger_veto = 1'b0;
        next_cycle();
    endtask

    task automatic test_accept_error();
        wait_drive_point();
        tlu_mode = MODE_FLAG;
        trigger  = 1'b1;  // line stuck high while idle
        repeat (2) next_cycle();
        check_bit("accept error raised", 1'b1, tlu_accept_error);
        wait_drive_point();
        trigger = 1'b0;
        repeat (2) next_cycle();
        check_bit("accept error cleared", 1'b0, tlu_accept_error);
    endtask

    initial
    begin
        void'($urandom(SEED));
        RESET               = 1'b1;
        trigger             = 1'b0;
        trigger_flag        = 1'b0;
        trigger_veto        = 1'b0;
        trigger_enable      = 1'b0;
        trigger_acknowledge = 1'b0;
        tlu_mode            = MODE_FLAG;
        tlu_clock_cycles    = '0;
        tlu_data_delay      = '0;
        tlu_low_timeout     = '0;
        tlu_msb_first       = 1'b0;
        write_timestamp     = 1'b0;
        counter_set         = 1'b0;
        counter_set_value   = '0;
        cnt_model           = '0;

        test_reset_idle();
        test_flag_counter();
        test_flag_timestamp();
        wait_drive_point();
        tlu_mode       = MODE_HANDSHAKE;
        tlu_data_delay = 4'd2;
        next_cycle();
        run_handshake("handshake 16 lsb", 5'd16, 1'b0, 1'b0);
        run_handshake("handshake 16 msb", 5'd16, 1'b1, 1'b0);
        run_handshake("handshake 32 lsb", 5'd0, 1'b0, 1'b0);
        run_handshake("handshake 32 msb", 5'd0, 1'b1, 1'b0);
        wait_drive_point();
        tlu_low_timeout = 8'd20;
        next_cycle();
        run_handshake("low timeout", 5'd16, 1'b0, 1'b1);
        wait_drive_point();
        tlu_low_timeout = '0;
        next_cycle();
        test_accept_error();

        $display("mismatches: %0d, other failures: %0d", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: tlu_controller.f
logic/tlu_timing_pkg.sv
logic/trigger_word_pkg.sv
logic/tlu_handshake_fsm.sv
logic/tlu_number_sampler.sv
logic/trigger_word_builder.sv
logic/tlu_controller.sv
verif/tb_tlu_controller.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the TLU controller testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f tlu_controller.f --top-module tb_tlu_controller -o tb_tlu_controller
output=$(./obj_dir/tb_tlu_controller)
echo "$output"
if echo "$output" | grep -qx "No errors"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
